// File: bench/mem_ctrl_tb.sv
`timescale 1ns/1ps

module mem_ctrl_tb;
    import mem_bus_pkg::*;

    localparam int timeout = 60;

    logic  clk;
    logic  rst;
    logic  if_req;
    addr_t if_addr;
    logic  if_ack;
    word_t if_data;
    logic  d_req;
    logic  d_we;
    addr_t d_addr;
    len_t  d_len;
    word_t d_wdata;
    logic  d_ack;
    word_t d_rdata;
    logic  ram_wr;
    addr_t ram_addr;
    byte_t ram_wdata;
    byte_t ram_rdata = '0;

    byte_t  ram [65536];
    integer seed = 32'haeae_821b;
    int     errors = 0;
    int     failed = 0;
    int     test_errors = 0;
    int     read_total = 0;
    addr_t  prev_addr = '0;
    logic   prev_wr = 1'b0;
    addr_t  wr_addr [$];
    byte_t  wr_data [$];

    tb_clock clock_gen (.clk(clk));

    mem_ctrl UUT (.*);

    // 64 KiB byte RAM with read data one cycle after the address
    always @(posedge clk) begin
        if (ram_wr) begin
            ram[ram_addr[15:0]] <= ram_wdata;
        end
        ram_rdata <= ram[ram_addr[15:0]];
    end

    // each issued read steps ram_addr by one
    always @(negedge clk) begin
        if (!prev_wr && ram_addr == prev_addr + 1) begin
            read_total++;
        end
        if (ram_wr) begin
            wr_addr.push_back(ram_addr);
            wr_data.push_back(ram_wdata);
        end
        prev_addr = ram_addr;
        prev_wr = ram_wr;
    end

    // little endian word from the model with bytes past n zero
    function automatic word_t ram_word(input addr_t a, input int n);
        word_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = ram[16'(a + i)];
        end
        return w;
    endfunction

    task automatic check_eq(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    // acks are looked at on the falling edge
    task automatic wait_ack(input bit data_port, input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while ((data_port ? d_ack : if_ack) !== level && n < timeout) begin
            @(negedge clk);
            n++;
        end
        if ((data_port ? d_ack : if_ack) !== level) begin
            $display("%s did not go to %0b within %0d cycles",
                     data_port ? "d_ack" : "if_ack", level, timeout);
            test_errors++;
        end
    endtask

    // one full four-phase handshake on either port with req held for hold extra cycles
    task automatic request(input bit data_port, input logic we, input addr_t a, input int n,
                           input word_t wd, input int hold, output word_t data,
                           output int reads);
        int    start;
        string ack_name;
        ack_name = data_port ? "d_ack" : "if_ack";
        @(posedge clk);
        start = read_total;
        if (data_port) begin
            d_req <= 1'b1;
            d_we <= we;
            d_addr <= a;
            d_len <= len_t'(n - 1);
            d_wdata <= wd;
        end else begin
            if_req <= 1'b1;
            if_addr <= a;
        end
        wait_ack(data_port, 1'b1);
        data = data_port ? d_rdata : if_data;
        reads = read_total - start;
        repeat (hold) begin
            @(negedge clk);
            check_eq(ack_name, data_port ? d_ack : if_ack, 1);
            check_eq(data_port ? "d_rdata" : "if_data", data_port ? d_rdata : if_data, data);
        end
        @(posedge clk);
        d_req <= 1'b0;
        if_req <= 1'b0;
        // ack drops one cycle after req
        @(negedge clk);
        check_eq(ack_name, data_port ? d_ack : if_ack, 1);
        @(negedge clk);
        check_eq(ack_name, data_port ? d_ack : if_ack, 0);
    endtask

    task automatic read_check(input bit data_port, input addr_t a, input int n,
                              input int exp_reads);
        word_t w;
        int    reads;
        request(data_port, 1'b0, a, n, '0, 0, w, reads);
        check_eq(data_port ? "d_rdata" : "if_data", w, ram_word(a, n));
        check_eq("ram read count", reads, exp_reads);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, test_errors);
            failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic fetch_miss_hit();
        read_check(1'b0, 32'h0000_0100, 4, 4);
        read_check(1'b0, 32'h0000_0100, 4, 0);
        finish_test("fetch miss then hit");
    endtask

    // third fill to one set evicts the first of three tags
    task automatic way_replacement();
        read_check(1'b0, 32'h0000_1040, 4, 4);
        read_check(1'b0, 32'h0000_2040, 4, 4);
        read_check(1'b0, 32'h0000_3040, 4, 4);
        read_check(1'b0, 32'h0000_2040, 4, 0);
        read_check(1'b0, 32'h0000_1040, 4, 4);
        finish_test("two-way replacement");
    endtask

    task automatic load_lengths();
        for (int len = 1; len <= 4; len++) begin
            read_check(1'b1, 32'h0000_4000 + 32'h101 * len, len, len);
        end
        finish_test("loads of 1 to 4 bytes");
    endtask

    task automatic store_lengths();
        addr_t a;
        word_t wd;
        word_t w;
        int    n;
        int    first;
        for (int len = 1; len <= 4; len++) begin
            a = 32'h0000_5000 + 32'h101 * len;
            wd = $random(seed);
            first = wr_addr.size();
            request(1'b1, 1'b1, a, len, wd, 0, w, n);
            if (wr_addr.size() - first != len) begin
                $display("store of %0d bytes gave %0d RAM writes", len, wr_addr.size() - first);
                test_errors++;
            end else begin
                for (int i = 0; i < len; i++) begin
                    check_eq("ram_addr", wr_addr[first + i], a + i);
                    check_eq("ram_wdata", wr_data[first + i], wd[8*i +: 8]);
                end
            end
            request(1'b1, 1'b0, a, len, '0, 0, w, n);
            check_eq("d_rdata", w, wd & ~(32'hffff_ffff << (8 * len)));
        end
        finish_test("stores of 1 to 4 bytes");
    endtask

    // fetch waits behind the load when both ports raise req together
    task automatic port_arbitration();
        @(posedge clk);
        if_req <= 1'b1;
        if_addr <= 32'h0000_6000;
        d_req <= 1'b1;
        d_we <= 1'b0;
        d_addr <= 32'h0000_6800;
        d_len <= 2'd3;
        wait_ack(1'b1, 1'b1);
        check_eq("if_ack", if_ack, 0);
        check_eq("d_rdata", d_rdata, ram_word(32'h0000_6800, 4));
        @(posedge clk);
        d_req <= 1'b0;
        wait_ack(1'b1, 1'b0);
        check_eq("if_ack", if_ack, 0);
        wait_ack(1'b0, 1'b1);
        check_eq("if_data", if_data, ram_word(32'h0000_6000, 4));
        @(posedge clk);
        if_req <= 1'b0;
        wait_ack(1'b0, 1'b0);
        finish_test("arbitration and back-pressure");
    endtask

    task automatic handshake_rule();
        word_t w;
        int    n;
        // reset lands while d_ack is high and d_req is still held
        @(posedge clk);
        d_req <= 1'b1;
        d_we <= 1'b0;
        d_addr <= 32'h0000_7000;
        d_len <= 2'd1;
        wait_ack(1'b1, 1'b1);
        @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_eq("if_ack", if_ack, 0);
        check_eq("d_ack", d_ack, 0);
        // held req is served again once out of reset
        request(1'b1, 1'b0, 32'h0000_7000, 2, '0, 5, w, n);
        check_eq("d_rdata", w, ram_word(32'h0000_7000, 2));
        finish_test("four-phase handshake");
    endtask

    initial begin
        rst <= 1'b1;
        if_req <= 1'b0;
        if_addr <= '0;
        d_req <= 1'b0;
        d_we <= 1'b0;
        d_addr <= '0;
        d_len <= '0;
        d_wdata <= '0;
        for (int i = 0; i < 65536; i++) begin
            ram[i] <= byte_t'($random(seed));
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        fetch_miss_hit();
        way_replacement();
        load_lengths();
        store_lengths();
        port_arbitration();
        handshake_rule();
        $display("6 tests, %0d failed, %0d errors", failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal -f verilog.f --top-module mem_ctrl_tb \
        -o mem_ctrl_sim \
    && ./obj_dir/mem_ctrl_sim | tee /dev/stderr | grep -x "RESULT: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: source/byte_counter.sv
`timescale 1ns/1ps

module byte_counter (
    input logic clk,
    input logic rst,
    byte_seq_if.count seq
);
    import mem_bus_pkg::*;

    // length is held for the whole transfer
    len_t len_q;

    assign seq.last = (seq.byte_idx == len_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            seq.ram_addr <= '0;
            seq.byte_idx <= '0;
            len_q <= '0;
        end else if (seq.start) begin
            seq.ram_addr <= seq.base;
            seq.byte_idx <= '0;
            len_q <= seq.len;
        end else if (seq.issue) begin
            seq.ram_addr <= seq.ram_addr + 1'b1;
            seq.byte_idx <= seq.byte_idx + 1'b1;
        end
    end

endmodule

// File: source/byte_seq_if.sv
`timescale 1ns/1ps

interface byte_seq_if;
    import mem_bus_pkg::*;

    logic      start;
    logic      issue;
    len_t      len;
    addr_t     base;
    addr_t     ram_addr;
    byte_idx_t byte_idx;
    logic      last;

    modport ctrl (output start, output issue, output len, output base, input last);

    modport count (
        input  start, input issue, input len, input base,
        output ram_addr, output byte_idx, output last
    );

    modport data (input start, input issue, input byte_idx);

endinterface

// File: source/icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int cache_index_width = icache_pkg::index_width
) (
    input  logic               clk,
    input  logic               rst,
    input  mem_bus_pkg::addr_t lookup_addr,
    input  logic               fill,
    input  mem_bus_pkg::word_t fill_word,
    output logic               hit,
    output mem_bus_pkg::word_t hit_word
);
    import mem_bus_pkg::*;
    import icache_pkg::*;

    localparam int sets = 1 << cache_index_width;

    // one bit per set, names the way that takes the next fill
    logic [sets-1:0]              repl;
    logic [cache_index_width-1:0] index;
    logic [1:0]                   way_hit;
    logic [1:0]                   way_fill;
    word_t                        way_word [2];

    assign index = lookup_addr[offset_width +: cache_index_width];
    assign way_fill[0] = fill && !repl[index];
    assign way_fill[1] = fill && repl[index];

    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_way #(
            .cache_index_width(cache_index_width)
        ) u_way (
            .clk(clk),
            .rst(rst),
            .lookup_addr(lookup_addr),
            .fill(way_fill[w]),
            .fill_word(fill_word),
            .hit(way_hit[w]),
            .hit_word(way_word[w])
        );
    end

    assign hit = |way_hit;
    assign hit_word = way_hit[0] ? way_word[0] : way_word[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            repl <= '0;
        end else if (fill) begin
            repl[index] <= ~repl[index];
        end
    end

endmodule

// File: source/icache_pkg.sv
package icache_pkg;

    // 64 sets by default
    localparam int index_width = 6;

    // word offset bits sit below the set index
    localparam int offset_width = 2;

    // tag is every address bit above the index
    function automatic int tag_width(int idx_width);
        return mem_bus_pkg::addr_width - idx_width - offset_width;
    endfunction

endpackage

// File: source/icache_way.sv
`timescale 1ns/1ps

module icache_way #(
    parameter int cache_index_width = icache_pkg::index_width
) (
    input  logic               clk,
    input  logic               rst,
    input  mem_bus_pkg::addr_t lookup_addr,
    input  logic               fill,
    input  mem_bus_pkg::word_t fill_word,
    output logic               hit,
    output mem_bus_pkg::word_t hit_word
);
    import mem_bus_pkg::*;
    import icache_pkg::*;

    localparam int sets = 1 << cache_index_width;
    localparam int tag_w = tag_width(cache_index_width);

    word_t                        data_mem [sets];
    logic [tag_w-1:0]             tag_mem [sets];
    logic [sets-1:0]              valid;
    logic [cache_index_width-1:0] index;
    logic [tag_w-1:0]             tag;

    assign index = lookup_addr[offset_width +: cache_index_width];
    assign tag = lookup_addr[addr_width-1 -: tag_w];

    assign hit = valid[index] && (tag_mem[index] == tag);
    assign hit_word = data_mem[index];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (fill) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            data_mem[index] <= fill_word;
            tag_mem[index] <= tag;
        end
    end

endmodule

// File: source/mem_bus_pkg.sv
package mem_bus_pkg;

    localparam int addr_width = 32;
    localparam int word_width = 32;
    localparam int byte_width = 8;

    // RAM is byte wide, words are little endian
    localparam int bytes_per_word = 4;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [word_width-1:0] word_t;
    typedef logic [byte_width-1:0] byte_t;

    // transfer length minus one
    typedef logic [1:0] len_t;

    typedef logic [$clog2(bytes_per_word)-1:0] byte_idx_t;

endpackage

// File: source/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl #(
    parameter int cache_index_width = icache_pkg::index_width
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               if_req,
    input  mem_bus_pkg::addr_t if_addr,
    output logic               if_ack,
    output mem_bus_pkg::word_t if_data,
    input  logic               d_req,
    input  logic               d_we,
    input  mem_bus_pkg::addr_t d_addr,
    input  mem_bus_pkg::len_t  d_len,
    input  mem_bus_pkg::word_t d_wdata,
    output logic               d_ack,
    output mem_bus_pkg::word_t d_rdata,
    output logic               ram_wr,
    output mem_bus_pkg::addr_t ram_addr,
    output mem_bus_pkg::byte_t ram_wdata,
    input  mem_bus_pkg::byte_t ram_rdata
);
    import mem_bus_pkg::*;

    logic  hit;
    logic  fill;
    logic  take_hit;
    word_t hit_word;
    word_t rdata;

    byte_seq_if seq ();

    assign ram_addr = seq.ram_addr;
    // one result word serves both ports
    assign if_data = rdata;
    assign d_rdata = rdata;

    mem_ctrl_fsm u_fsm (
        .clk(clk), .rst(rst), .seq(seq.ctrl),
        .if_req(if_req), .if_addr(if_addr),
        .d_req(d_req), .d_we(d_we), .d_addr(d_addr), .d_len(d_len),
        .hit(hit), .fill(fill), .take_hit(take_hit), .ram_wr(ram_wr),
        .if_ack(if_ack), .d_ack(d_ack)
    );

    byte_counter u_counter (.clk(clk), .rst(rst), .seq(seq.count));

    word_buffer u_buffer (
        .clk(clk), .rst(rst), .seq(seq.data),
        .wdata(d_wdata), .hit_word(hit_word), .take_hit(take_hit),
        .ram_rdata(ram_rdata), .ram_wdata(ram_wdata), .rdata(rdata)
    );

    icache #(.cache_index_width(cache_index_width)) u_icache (
        .clk(clk), .rst(rst), .lookup_addr(if_addr), .fill(fill),
        .fill_word(rdata), .hit(hit), .hit_word(hit_word)
    );

endmodule

// File: source/mem_ctrl_fsm.sv
`timescale 1ns/1ps

module mem_ctrl_fsm (
    input  logic               clk,
    input  logic               rst,
    byte_seq_if.ctrl           seq,
    input  logic               if_req,
    input  mem_bus_pkg::addr_t if_addr,
    input  logic               d_req,
    input  logic               d_we,
    input  mem_bus_pkg::addr_t d_addr,
    input  mem_bus_pkg::len_t  d_len,
    input  logic               hit,
    output logic               fill,
    output logic               take_hit,
    output logic               ram_wr,
    output logic               if_ack,
    output logic               d_ack
);
    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        idle,
        load,
        store,
        respond
    } seq_state_t;

    seq_state_t state;
    logic       serve_d;
    logic       hit_wait;
    logic       fill_pend;
    logic       served_req;

    assign served_req = serve_d ? d_req : if_req;

    // data port wins when both request
    assign seq.start = (state == idle) && (d_req || (if_req && !hit));
    assign seq.base = d_req ? d_addr : if_addr;
    assign seq.len = d_req ? d_len : len_t'(bytes_per_word - 1);
    assign seq.issue = (state == load) || (state == store);

    assign ram_wr = (state == store);
    assign take_hit = (state == respond) && hit_wait;
    // fill lands with the first cycle of if_ack
    assign fill = (state == respond) && if_ack && fill_pend;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            serve_d <= 1'b0;
            hit_wait <= 1'b0;
            fill_pend <= 1'b0;
            if_ack <= 1'b0;
            d_ack <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (d_req) begin
                        serve_d <= 1'b1;
                        state <= d_we ? store : load;
                    end else if (if_req) begin
                        serve_d <= 1'b0;
                        if (hit) begin
                            hit_wait <= 1'b1;
                            state <= respond;
                        end else begin
                            fill_pend <= 1'b1;
                            state <= load;
                        end
                    end
                end
                load, store: begin
                    if (seq.last) begin
                        state <= respond;
                    end
                end
                respond: begin
                    if (if_ack) begin
                        fill_pend <= 1'b0;
                    end
                    // hit word goes into the buffer before ack
                    if (hit_wait) begin
                        hit_wait <= 1'b0;
                    end else if (served_req) begin
                        d_ack <= serve_d;
                        if_ack <= !serve_d;
                    end else begin
                        d_ack <= 1'b0;
                        if_ack <= 1'b0;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// File: source/word_buffer.sv
`timescale 1ns/1ps

module word_buffer (
    input  logic               clk,
    input  logic               rst,
    byte_seq_if.data           seq,
    input  mem_bus_pkg::word_t wdata,
    input  mem_bus_pkg::word_t hit_word,
    input  logic               take_hit,
    input  mem_bus_pkg::byte_t ram_rdata,
    output mem_bus_pkg::byte_t ram_wdata,
    output mem_bus_pkg::word_t rdata
);
    import mem_bus_pkg::*;

    word_t     store_q;
    logic      cap_valid;
    byte_idx_t cap_idx;

    assign ram_wdata = store_q[seq.byte_idx * byte_width +: byte_width];

    // RAM answers one cycle after the address
    always_ff @(posedge clk) begin
        if (rst) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= seq.issue;
        end
    end

    always_ff @(posedge clk) begin
        cap_idx <= seq.byte_idx;
        if (seq.start) begin
            store_q <= wdata;
            // bytes not loaded read as zero
            rdata <= '0;
        end else if (take_hit) begin
            rdata <= hit_word;
        end else if (cap_valid) begin
            rdata[cap_idx * byte_width +: byte_width] <= ram_rdata;
        end
    end

endmodule

// File: verilog.f
source/mem_bus_pkg.sv
source/icache_pkg.sv
source/byte_seq_if.sv
source/icache_way.sv
source/icache.sv
source/byte_counter.sv
source/word_buffer.sv
source/mem_ctrl_fsm.sv
source/mem_ctrl.sv
bench/tb_clock.sv
bench/mem_ctrl_tb.sv
